// ==== Makefile ====
# Verilator flow for the super-block controller

VERILATOR ?= verilator
TOP       ?= sblk_ctrl_tb
RTL_TOP   ?= sblk_ctrl
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/actbuf_fill_ctrl.sv ====
`timescale 1ns/1ps

`include "sblk_defs.svh"

`default_nettype none

module actbuf_fill_ctrl
    import sblk_cfg_pkg::*;
    import sblk_buf_pkg::*;
(
    input  logic       clk_l,
    input  logic       rst_n,
    input  logic       fill_busy,
    input  logic       fill_bank,
    input  logic       actbuf_wr_vld,
    input  act_row_t   fill_rows,
    output logic       actbuf_wr_req,
    output logic       fill_done,
    output actbuf_wr_t actbuf_wr
);

    localparam int D1 = `SBLK_D1;

    logic [`SBLK_D1_W-1:0] lane_cnt;
    act_row_t              row_cnt;
    logic                  accept;
    logic                  lane_last;
    logic                  row_last;

    // word taken only while we are asking for it
    assign accept    = actbuf_wr_vld & actbuf_wr_req;
    assign lane_last = (lane_cnt == `SBLK_D1_W'(D1 - 1));
    assign row_last  = (row_cnt == fill_rows - act_row_t'(1));
    // last lane of last row, same cycle as the final write
    assign fill_done = accept & lane_last & row_last;

    // strobes straight off the handshake
    always_comb begin
        actbuf_wr.lane_en = accept ? (`SBLK_D1'(1) << lane_cnt) : '0;
        actbuf_wr.bank    = fill_bank;
        actbuf_wr.row     = row_cnt;
    end

    // request held for the whole fill, dropped after the last word
    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            actbuf_wr_req <= 1'b0;
        end else if (fill_done) begin
            actbuf_wr_req <= 1'b0;
        end else if (fill_busy) begin
            actbuf_wr_req <= 1'b1;
        end
    end

    // round-robin lanes, row steps once per sweep
    // both wrap to zero on the last word, ready for the next bank
    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            lane_cnt <= '0;
            row_cnt  <= '0;
        end else if (accept) begin
            if (lane_last) begin
                lane_cnt <= '0;
                row_cnt  <= row_last ? '0 : row_cnt + act_row_t'(1);
            end else begin
                lane_cnt <= lane_cnt + `SBLK_D1_W'(1);
            end
        end
    end

endmodule : actbuf_fill_ctrl

`default_nettype wire

// ==== design/actbuf_pingpong.sv ====
`timescale 1ns/1ps

`default_nettype none

module actbuf_pingpong (
    input  logic clk_l,
    input  logic rst_n,
    input  logic cfg_ready,
    input  logic fill_done,
    input  logic calc_done,
    output logic fill_busy,
    output logic calc_busy,
    output logic fill_bank,
    output logic calc_bank,
    output logic swap
);

    // first fill only, both phases idle before the first config
    logic first_fill;

    assign first_fill = cfg_ready & ~fill_busy & ~calc_busy;

    // swap when both finish together,
    // or when one finishes and the other has nothing running
    assign swap = (fill_done & calc_done)
                | (fill_done & ~calc_busy)
                | (calc_done & ~fill_busy);

    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            fill_busy <= 1'b0;
            calc_busy <= 1'b0;
            fill_bank <= 1'b0;
            calc_bank <= 1'b1;
        end else if (swap) begin
            // new round, both phases restart on flipped banks
            fill_busy <= 1'b1;
            calc_busy <= 1'b1;
            fill_bank <= ~fill_bank;
            calc_bank <= ~calc_bank;
        end else begin
            // a phase that ends early waits idle for the other
            if (first_fill) begin
                fill_busy <= 1'b1;
            end else if (fill_done) begin
                fill_busy <= 1'b0;
            end
            if (calc_done) begin
                calc_busy <= 1'b0;
            end
        end
    end

endmodule : actbuf_pingpong

`default_nettype wire

// ==== design/calc_loop_nest.sv ====
`timescale 1ns/1ps

`include "sblk_defs.svh"

`default_nettype none

module calc_loop_nest
    import sblk_cfg_pkg::*;
    import sblk_buf_pkg::*;
(
    input  logic           clk_l,
    input  logic           rst_n,
    input  logic           calc_busy,
    input  logic           calc_bank,
    input  sblk_loop_cfg_t loop_cfg,
    output logic           calc_done,
    output actbuf_rd_t     actbuf_rd,
    output pbuf_port_t     pbuf_rd
);

    localparam int AW = `SBLK_PBUF_ADDR_W;
    // per level stride, t0 walks in pairs
    localparam loop_idx_t STEP [4] = '{loop_idx_t'(1), loop_idx_t'(2),
                                       loop_idx_t'(1), loop_idx_t'(1)};

    logic      calc_en;
    // nest order, innermost first: t1, t0, t2, t3
    loop_idx_t cnt  [4];
    loop_idx_t last [4];
    // adv[k] steps level k, adv[4] is the wrap of the whole nest
    logic [4:0] adv;

    logic [AW-1:0] plane;
    logic [AW-1:0] inner;
    logic [AW-1:0] act_row_nxt;
    logic [AW-1:0] pbuf_addr_nxt;

    // per level terminal value
    always_comb begin
        last[0] = loop_cfg.loop_p1 - loop_idx_t'(1);
        last[1] = loop_cfg.loop_p0 - loop_idx_t'(2);
        last[2] = loop_cfg.loop_p2 - loop_idx_t'(1);
        last[3] = loop_cfg.loop_p3 - loop_idx_t'(1);
    end

    // a level moves when every inner level wraps
    always_comb begin
        adv[0] = calc_en;
        for (int k = 0; k < 4; k++) begin
            adv[k+1] = adv[k] & (cnt[k] == last[k]);
        end
    end

    assign calc_done = adv[4];

    // one iteration per cycle, no stall
    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            calc_en <= 1'b0;
        end else if (calc_done) begin
            calc_en <= 1'b0;
        end else if (calc_busy) begin
            calc_en <= 1'b1;
        end
    end

    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 4; k++) begin
                cnt[k] <= '0;
            end
        end else begin
            for (int k = 0; k < 4; k++) begin
                if (adv[k]) begin
                    cnt[k] <= adv[k+1] ? '0 : cnt[k] + STEP[k];
                end
            end
        end
    end

    // p0*p1 words per t2 or t3 step
    assign plane         = AW'(loop_cfg.loop_p0) * AW'(loop_cfg.loop_p1);
    // t0*p1 + t1, shared by both buffers
    assign inner         = AW'(cnt[1]) * AW'(loop_cfg.loop_p1) + AW'(cnt[0]);
    assign act_row_nxt   = AW'(cnt[2]) * plane + inner;
    assign pbuf_addr_nxt = AW'(cnt[3]) * plane + inner;

    // enables cleared at reset
    // addresses and bank in the same cycle as the enables
    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            actbuf_rd <= '0;
            pbuf_rd   <= '0;
        end else begin
            actbuf_rd.en   <= calc_en;
            actbuf_rd.bank <= calc_bank;
            actbuf_rd.row  <= act_row_t'(act_row_nxt);
            pbuf_rd.en     <= calc_en;
            pbuf_rd.addr   <= pbuf_addr_nxt;
        end
    end

endmodule : calc_loop_nest

`default_nettype wire

// ==== design/sblk_buf_pkg.sv ====
`include "sblk_defs.svh"

`default_nettype none

package sblk_buf_pkg;

    import sblk_cfg_pkg::*;

    // activation buffer write strobes
    // lane_en one-hot, zero when no word is taken
    typedef struct packed {
        logic [`SBLK_D1-1:0] lane_en;
        logic                bank;
        act_row_t            row;
    } actbuf_wr_t;

    // activation buffer read port
    typedef struct packed {
        logic     en;
        logic     bank;
        act_row_t row;
    } actbuf_rd_t;

    // partial-sum port, same shape for read and write
    typedef struct packed {
        logic                         en;
        logic [`SBLK_PBUF_ADDR_W-1:0] addr;
    } pbuf_port_t;

endpackage : sblk_buf_pkg

`default_nettype wire

// ==== design/sblk_cfg_pkg.sv ====
`include "sblk_defs.svh"

`default_nettype none

package sblk_cfg_pkg;

    // one loop bound or one loop index
    typedef logic [`SBLK_LOOP_W-1:0] loop_idx_t;

    // row inside one activation bank
    typedef logic [`SBLK_ACT_ROW_W-1:0] act_row_t;

    // temporal loop bounds, p0 in the low bits
    // p0 even and >= 2, walked in steps of two
    // p1..p3 at least one
    typedef struct packed {
        loop_idx_t loop_p3;
        loop_idx_t loop_p2;
        loop_idx_t loop_p1;
        loop_idx_t loop_p0;
    } sblk_loop_cfg_t;

endpackage : sblk_cfg_pkg

`default_nettype wire

// ==== design/sblk_cfg_reg.sv ====
`timescale 1ns/1ps

`include "sblk_defs.svh"

`default_nettype none

module sblk_cfg_reg
    import sblk_cfg_pkg::*;
(
    input  logic           clk_l,
    input  logic           rst_n,
    input  logic           temp_param_en,
    input  sblk_loop_cfg_t temp_param,
    output sblk_loop_cfg_t loop_cfg,
    output act_row_t       fill_rows,
    output logic           cfg_ready
);

    localparam int PROD_W = 3 * `SBLK_LOOP_W;

    // set the cycle after capture, fill_rows computed from it
    logic              cap_pend;
    // p0*p1*p2, two lane sweeps per row pair
    logic [PROD_W-1:0] loop_vol;

    assign loop_vol = PROD_W'(loop_cfg.loop_p0) * PROD_W'(loop_cfg.loop_p1)
                    * PROD_W'(loop_cfg.loop_p2);

    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            loop_cfg  <= '0;
            cap_pend  <= 1'b0;
            fill_rows <= '0;
            cfg_ready <= 1'b0;
        end else begin
            // bounds captured one cycle after the strobe
            if (temp_param_en) begin
                loop_cfg <= temp_param;
            end
            cap_pend  <= temp_param_en;
            // rows per fill, multiplier off the capture path
            if (cap_pend) begin
                fill_rows <= act_row_t'(loop_vol >> 1);
            end
            // ready together with the new row count
            cfg_ready <= cap_pend;
        end
    end

endmodule : sblk_cfg_reg

`default_nettype wire

// ==== design/sblk_ctrl.sv ====
`timescale 1ns/1ps

`include "sblk_defs.svh"

`default_nettype none

module sblk_ctrl
    import sblk_cfg_pkg::*;
    import sblk_buf_pkg::*;
(
    input  logic           clk_l,
    input  logic           rst_n,
    input  logic           temp_param_en,
    input  sblk_loop_cfg_t temp_param,
    input  logic           actbuf_wr_vld,
    output logic           actbuf_wr_req,
    output logic           sblk_status,
    output actbuf_wr_t     actbuf_wr,
    output actbuf_rd_t     actbuf_rd,
    output pbuf_port_t     pbuf_rd,
    output pbuf_port_t     pbuf_wr
);

    sblk_loop_cfg_t loop_cfg;
    act_row_t       fill_rows;
    logic           cfg_ready;
    logic           fill_busy;
    logic           calc_busy;
    logic           fill_bank;
    logic           calc_bank;
    logic           fill_done;
    logic           calc_done;

    sblk_cfg_reg i_cfg_reg (
        .clk_l         (clk_l),
        .rst_n         (rst_n),
        .temp_param_en (temp_param_en),
        .temp_param    (temp_param),
        .loop_cfg      (loop_cfg),
        .fill_rows     (fill_rows),
        .cfg_ready     (cfg_ready)
    );

    // swap decision doubles as the round status pulse
    actbuf_pingpong i_pingpong (
        .clk_l     (clk_l),
        .rst_n     (rst_n),
        .cfg_ready (cfg_ready),
        .fill_done (fill_done),
        .calc_done (calc_done),
        .fill_busy (fill_busy),
        .calc_busy (calc_busy),
        .fill_bank (fill_bank),
        .calc_bank (calc_bank),
        .swap      (sblk_status)
    );

    actbuf_fill_ctrl i_fill_ctrl (
        .clk_l         (clk_l),
        .rst_n         (rst_n),
        .fill_busy     (fill_busy),
        .fill_bank     (fill_bank),
        .actbuf_wr_vld (actbuf_wr_vld),
        .fill_rows     (fill_rows),
        .actbuf_wr_req (actbuf_wr_req),
        .fill_done     (fill_done),
        .actbuf_wr     (actbuf_wr)
    );

    calc_loop_nest i_loop_nest (
        .clk_l     (clk_l),
        .rst_n     (rst_n),
        .calc_busy (calc_busy),
        .calc_bank (calc_bank),
        .loop_cfg  (loop_cfg),
        .calc_done (calc_done),
        .actbuf_rd (actbuf_rd),
        .pbuf_rd   (pbuf_rd)
    );

    // partial-sum write trails the read through the mac pipeline
    sblk_delay_line #(
        .payload_t (pbuf_port_t),
        .DEPTH     (`SBLK_PBUF_WR_DELAY)
    ) i_pbuf_wr_dly (
        .clk_l (clk_l),
        .rst_n (rst_n),
        .din   (pbuf_rd),
        .dout  (pbuf_wr)
    );

endmodule : sblk_ctrl

`default_nettype wire

// ==== design/sblk_defs.svh ====
`ifndef SBLK_DEFS_SVH
`define SBLK_DEFS_SVH

// activation lanes per super-block
`define SBLK_D1 4

// lane index width, log2 of the lane count
`define SBLK_D1_W 2

// one temporal loop bound
`define SBLK_LOOP_W 6

// row address inside one activation bank
`define SBLK_ACT_ROW_W 9

// partial-sum buffer address
`define SBLK_PBUF_ADDR_W 10

// pbuf read to write latency
// 4 stage mac, adder tree over half the lanes, one output register
`define SBLK_PBUF_WR_DELAY (4 + (`SBLK_D1 + 1) / 2 + 1)

`endif

// ==== design/sblk_delay_line.sv ====
`timescale 1ns/1ps

`default_nettype none

module sblk_delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk_l,
    input  logic     rst_n,
    input  payload_t din,
    output payload_t dout
);

    payload_t stage [DEPTH];

    // zero on reset so no stale enable comes out
    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule : sblk_delay_line

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/sblk_cfg_pkg.sv
design/sblk_buf_pkg.sv
design/sblk_cfg_reg.sv
design/actbuf_pingpong.sv
design/actbuf_fill_ctrl.sv
design/calc_loop_nest.sv
design/sblk_delay_line.sv
design/sblk_ctrl.sv
sim/sblk_ctrl_sva.sv
sim/sblk_ctrl_tb.sv

// ==== sim/sblk_ctrl_sva.sv ====
`timescale 1ns/1ps

`include "sblk_defs.svh"

`default_nettype none

module sblk_ctrl_sva
    import sblk_buf_pkg::*;
(
    input logic       clk_l,
    input logic       rst_n,
    input logic       actbuf_wr_vld,
    input logic       actbuf_wr_req,
    input logic       sblk_status,
    input actbuf_wr_t actbuf_wr,
    input pbuf_port_t pbuf_rd,
    input pbuf_port_t pbuf_wr
);

    localparam int DLY = `SBLK_PBUF_WR_DELAY;

    logic accept;

    assign accept = actbuf_wr_vld & actbuf_wr_req;

    // one lane per accepted word
    lane_onehot: assert property (@(posedge clk_l) disable iff (!rst_n)
        accept |-> $onehot(actbuf_wr.lane_en))
        else $error("lane strobe not one-hot on an accepted word");

    // quiet strobes between words
    lane_idle: assert property (@(posedge clk_l) disable iff (!rst_n)
        !accept |-> (actbuf_wr.lane_en == '0))
        else $error("lane strobe set without an accepted word");

    status_pulse: assert property (@(posedge clk_l) disable iff (!rst_n)
        sblk_status |=> !sblk_status)
        else $error("status held for two cycles");

    // write enable trails read enable through the mac pipeline
    pbuf_wr_lag: assert property (@(posedge clk_l) disable iff (!rst_n)
        pbuf_wr.en == $past(pbuf_rd.en, DLY))
        else $error("partial-sum write enable out of step with read");

endmodule : sblk_ctrl_sva

bind sblk_ctrl sblk_ctrl_sva i_sblk_ctrl_sva (
    .clk_l         (clk_l),
    .rst_n         (rst_n),
    .actbuf_wr_vld (actbuf_wr_vld),
    .actbuf_wr_req (actbuf_wr_req),
    .sblk_status   (sblk_status),
    .actbuf_wr     (actbuf_wr),
    .pbuf_rd       (pbuf_rd),
    .pbuf_wr       (pbuf_wr)
);

`default_nettype wire

// ==== sim/sblk_ctrl_tb.sv ====
`timescale 1ns/1ps

`include "sblk_defs.svh"

`default_nettype none

module sblk_ctrl_tb
    import sblk_cfg_pkg::*;
    import sblk_buf_pkg::*;
();

    localparam int D1         = `SBLK_D1;
    localparam int DLY        = `SBLK_PBUF_WR_DELAY;
    localparam int CLK_PERIOD = 4;
    localparam int ROUNDS     = 3;
    // largest config the random draw can produce, every bound at 8
    localparam int MAX_R      = 8 * 8 * 8 / 2;
    localparam int MAX_N      = 4 * 8 * 8 * 8;
    localparam int ROUND_CYC  = 2 * D1 * MAX_R + MAX_N + DLY + 20;
    localparam int WDOG_CYC   = ROUNDS * ROUND_CYC + 16 + 40;
    // test ids
    localparam int T_RESET = 0;
    localparam int T_FILL  = 1;
    localparam int T_SWAP  = 2;
    localparam int T_READ  = 3;
    localparam int T_PBUF  = 4;

    logic           clk_l;
    logic           rst_n;
    logic           temp_param_en;
    sblk_loop_cfg_t temp_param;
    logic           actbuf_wr_vld;
    logic           actbuf_wr_req;
    logic           sblk_status;
    actbuf_wr_t     actbuf_wr;
    actbuf_rd_t     actbuf_rd;
    pbuf_port_t     pbuf_rd;
    pbuf_port_t     pbuf_wr;

    // model state
    int          errs [5];
    int          checks [5];
    string       test_name [5];
    int          act_q [$];
    int          prd_q [$];
    int          infl_cyc [$];
    int          infl_addr [$];
    int          cyc;
    int          acc_cnt;
    int          rd_cnt;
    int          wr_cnt;
    int          swap_cnt;
    int          fill_words;
    int          exp_bank;
    logic        fill_on;
    logic        cfg_loaded;
    logic        req_drop_chk;
    logic [31:0] vld_state;
    logic [31:0] cfg_state;

    sblk_ctrl i_sblk_ctrl (
        .clk_l         (clk_l),
        .rst_n         (rst_n),
        .temp_param_en (temp_param_en),
        .temp_param    (temp_param),
        .actbuf_wr_vld (actbuf_wr_vld),
        .actbuf_wr_req (actbuf_wr_req),
        .sblk_status   (sblk_status),
        .actbuf_wr     (actbuf_wr),
        .actbuf_rd     (actbuf_rd),
        .pbuf_rd       (pbuf_rd),
        .pbuf_wr       (pbuf_wr)
    );

    always #(CLK_PERIOD / 2) clk_l = ~clk_l;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_val(input int test, input string what, input int exp, input int act);
        checks[test]++;
        if (exp != act) begin
            errs[test]++;
            $display("FAILED %s: %s expected %0d actual %0d", test_name[test], what, exp, act);
        end
    endtask

    // golden loop order, innermost t1 then t0 by two, t2, t3
    task automatic build_model(input int p0, input int p1, input int p2, input int p3);
        for (int t3 = 0; t3 < p3; t3++) begin
            for (int t2 = 0; t2 < p2; t2++) begin
                for (int t0 = 0; t0 < p0; t0 += 2) begin
                    for (int t1 = 0; t1 < p1; t1++) begin
                        act_q.push_back(t2 * p0 * p1 + t0 * p1 + t1);
                        prd_q.push_back(t3 * p0 * p1 + t0 * p1 + t1);
                    end
                end
            end
        end
    endtask

    always @(posedge clk_l) begin
        cyc++;
        vld_state = lcg_next(vld_state);
        // roughly 30 % gaps
        actbuf_wr_vld <= fill_on & ((int'(vld_state[31:24]) % 10) >= 3);
    end

    // sample after the drive edge settles
    always @(negedge clk_l) begin
        if (rst_n) begin
            if (!cfg_loaded) begin
                check_val(T_RESET, "wr_req", 0, int'(actbuf_wr_req));
                check_val(T_RESET, "rd en", 0, int'(actbuf_rd.en | pbuf_rd.en | pbuf_wr.en));
                check_val(T_RESET, "status", 0, int'(sblk_status));
            end
            if (req_drop_chk) begin
                check_val(T_FILL, "req after last word", 0, int'(actbuf_wr_req));
                req_drop_chk = 1'b0;
            end
            if (actbuf_wr_vld && actbuf_wr_req) begin
                check_val(T_FILL, "lane_en", 1 << (acc_cnt % D1), int'(actbuf_wr.lane_en));
                check_val(T_FILL, "row", acc_cnt / D1, int'(actbuf_wr.row));
                check_val(T_SWAP, "fill bank", exp_bank, int'(actbuf_wr.bank));
                acc_cnt++;
                if (acc_cnt == fill_words) begin
                    fill_on      = 1'b0;
                    req_drop_chk = 1'b1;
                    check_val(T_SWAP, "status on last word", 1, int'(sblk_status));
                end
            end
            if (sblk_status) begin
                swap_cnt++;
            end
            if (actbuf_rd.en) begin
                rd_cnt++;
                check_val(T_SWAP, "calc bank", exp_bank, int'(actbuf_rd.bank));
                if (act_q.size() == 0 || prd_q.size() == 0) begin
                    errs[T_READ]++;
                    $display("read issued beyond the end of the loop nest");
                end else begin
                    check_val(T_READ, "act row", act_q.pop_front(), int'(actbuf_rd.row));
                    check_val(T_READ, "pbuf rd addr", prd_q.pop_front(), int'(pbuf_rd.addr));
                end
            end
            if (pbuf_rd.en) begin
                infl_cyc.push_back(cyc);
                infl_addr.push_back(int'(pbuf_rd.addr));
            end
            if (pbuf_wr.en) begin
                wr_cnt++;
                if (infl_cyc.size() == 0) begin
                    errs[T_PBUF]++;
                    $display("partial-sum write with no read in flight");
                end else begin
                    check_val(T_PBUF, "wr latency", DLY, cyc - infl_cyc.pop_front());
                    check_val(T_PBUF, "wr addr", infl_addr.pop_front(), int'(pbuf_wr.addr));
                end
            end
        end
    end

    // hard stop sized for three rounds at the largest config
    initial begin
        #(WDOG_CYC * CLK_PERIOD);
        $display("watchdog expired, the DUT stopped making progress");
        $display("Test failures found");
        $finish;
    end

    initial begin
        int p0;
        int p1;
        int p2;
        int p3;
        int n_iter;
        int total_chk;
        int total_err;
        test_name = '{"reset", "fill", "swap", "act_read", "pbuf_pipe"};
        errs = '{default: 0};
        checks = '{default: 0};
        clk_l = 1'b0;
        rst_n = 1'b0;
        temp_param_en = 1'b0;
        temp_param = '0;
        actbuf_wr_vld = 1'b0;
        cyc = 0;
        acc_cnt = 0;
        rd_cnt = 0;
        wr_cnt = 0;
        swap_cnt = 0;
        fill_words = 0;
        exp_bank = 0;
        fill_on = 1'b0;
        cfg_loaded = 1'b0;
        req_drop_chk = 1'b0;
        cfg_state = 32'h7a06_640d;
        vld_state = lcg_next(32'h7a06_640d);
        repeat (16) @(posedge clk_l);
        rst_n <= 1'b1;
        // idle window, nothing may move without a config
        repeat (20) @(posedge clk_l);
        for (int r = 0; r < ROUNDS; r++) begin
            cfg_state = lcg_next(cfg_state);
            p0 = 2 * (1 + int'(cfg_state[31:30]));
            p1 = 1 + int'(cfg_state[29:27]);
            p2 = 1 + int'(cfg_state[26:24]);
            p3 = 1 + int'(cfg_state[23:21]);
            n_iter = (p0 / 2) * p1 * p2 * p3;
            build_model(p0, p1, p2, p3);
            acc_cnt = 0;
            rd_cnt = 0;
            wr_cnt = 0;
            fill_words = D1 * (p0 * p1 * p2 / 2);
            exp_bank = r % 2;
            $display("round %0d: p0 %0d p1 %0d p2 %0d p3 %0d", r, p0, p1, p2, p3);
            // loaded while calc is idle and no word of this fill is taken yet
            temp_param_en <= 1'b1;
            temp_param <= '{loop_p3: loop_idx_t'(p3), loop_p2: loop_idx_t'(p2),
                            loop_p1: loop_idx_t'(p1), loop_p0: loop_idx_t'(p0)};
            cfg_loaded = 1'b1;
            @(posedge clk_l);
            temp_param_en <= 1'b0;
            repeat (3) @(posedge clk_l);
            @(negedge clk_l);
            fill_on = 1'b1;
            wait (acc_cnt == fill_words);
            wait (rd_cnt == n_iter && wr_cnt == n_iter);
            repeat (2) @(posedge clk_l);
            check_val(T_SWAP, "swap count", r + 1, swap_cnt);
            check_val(T_PBUF, "writes left", 0, infl_cyc.size());
        end
        total_chk = 0;
        total_err = 0;
        for (int t = 0; t < 5; t++) begin
            $display("test %s checks %0d errors %0d", test_name[t], checks[t], errs[t]);
            total_chk += checks[t];
            total_err += errs[t];
        end
        $display("tests 5 checks %0d errors %0d", total_chk, total_err);
        if (total_err == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : sblk_ctrl_tb

`default_nettype wire
